//--- sata_transport.f
+incdir+logic
logic/sata_fis_pkg.sv
logic/sata_link_pkg.sv
logic/fis_type_decode.sv
logic/transport_ctrl.sv
logic/h2d_reg_framer.sv
logic/d2h_reg_capture.sv
logic/sata_transport.sv
tb/sata_transport_tb.sv

//--- tb/sata_transport_tb.sv
// Testbench for the transport layer with link layer model, reference packing and dword checker
`timescale 1ns/10ps
`include "sata_transport_defines.svh"

module sata_transport_tb import sata_fis_pkg::*, sata_link_pkg::*; ();

  localparam int WAIT_LIMIT = 50;

  logic      clk;
  logic      rst;
  logic      send_command_stb;
  logic      send_control_stb;
  logic      sync_escape;
  h2d_regs_t h2d;
  logic      transport_layer_ready;
  d2h_regs_t d2h;
  logic      d2h_reg_stb;
  logic      set_device_bits_stb;
  logic      dma_activate_stb;
  logic      link_layer_ready;
  logic      phy_ready;
  ll_rx_t    ll_rx;
  logic      ll_write_strobe;
  logic      ll_write_finished;
  logic      ll_xmit_error;
  ll_tx_t    ll_tx;
  logic      ll_read_ready;
  logic      ll_sync_escape;

  logic [4:0][31:0] exp_dw;
  logic [4:0][31:0] rx_dw;
  d2h_regs_t        exp_d2h;
  logic [31:0]      sent_q[$];
  int               errors;
  int               tests;
  int               failed_tests;
  int               test_errs;
  int               frames_checked;
  int               base;
  int               k;
  bit               timed_out;
  string            test_name;
  int unsigned      seed;

  sata_transport i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Register FIS layout as the device expects it
  function automatic logic [4:0][31:0] h2d_ref(input h2d_regs_t r, input logic c);
    logic [4:0][31:0] d;
    d[0] = {r.features[7:0], r.command, c, 3'b000, r.port_mult, `FIS_H2D_REG};
    d[1] = {r.device, r.lba[23:0]};
    d[2] = {r.features[15:8], r.lba[47:24]};
    d[3] = {r.control, 8'h00, r.sector_count};
    d[4] = 32'h0;
    return d;
  endfunction

  // Device register update for one received frame
  function automatic d2h_regs_t d2h_ref(input d2h_regs_t prev, input logic [4:0][31:0] dw);
    d2h_regs_t r;
    logic [7:0] code;
    r = prev;
    code = dw[0][7:0];
    if (code == `FIS_D2H_REG || code == `FIS_SET_DEV_BITS || code == `FIS_DMA_ACT) begin
      r.interrupt = dw[0][14];
      r.port_mult = dw[0][11:8];
    end
    if (code == `FIS_D2H_REG) begin
      r.status       = dw[0][23:16];
      r.error        = dw[0][31:24];
      r.device       = dw[1][31:24];
      r.lba          = {dw[2][23:0], dw[1][23:0]};
      r.sector_count = dw[3][15:0];
    end else if (code == `FIS_SET_DEV_BITS) begin
      r.status[6:4]  = dw[0][22:20];
      r.status[2:0]  = dw[0][18:16];
      r.error        = dw[0][31:24];
      r.notification = dw[0][15];
    end
    return r;
  endfunction

  function automatic h2d_regs_t rand_h2d();
    return 108'({$urandom, $urandom, $urandom, $urandom});
  endfunction

  task automatic expect_eq(input string what, input logic [127:0] got, input logic [127:0] exp);
    assert (got === exp) else begin
      $display("FAILED %0t: %s got %0h expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic abort_run(input string what);
    $display("ERROR: timed out waiting for %s", what);
    timed_out = 1'b1;
    disable run_tests;
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!transport_layer_ready && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!transport_layer_ready) abort_run("transport_layer_ready");
  endtask

  task automatic wait_start();
    int n;
    n = 0;
    while (!ll_tx.start && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!ll_tx.start) abort_run("ll_tx.start");
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = errors;
  endtask

  task automatic finish_test();
    tests++;
    if (errors == test_errs) begin
      $display("test %0d %s: ok", tests, test_name);
    end else begin
      failed_tests++;
      $display("test %0d %s: %0d errors", tests, test_name, errors - test_errs);
    end
  endtask

  // Command or control strobe, start must follow one cycle later
  task automatic launch_send(input logic cmd);
    wait_ready();
    expect_eq("start before strobe", ll_tx.start, 1'b0);
    send_command_stb = cmd;
    send_control_stb = !cmd;
    @(negedge clk);
    send_command_stb = 1'b0;
    send_control_stb = 1'b0;
    expect_eq("start after strobe", ll_tx.start, 1'b1);
    expect_eq("ready after strobe", transport_layer_ready, 1'b0);
  endtask

  // Link layer side of a send, random gaps between dwords
  task automatic link_phase(input logic err);
    int i;
    for (i = 0; i < `FIS_H2D_REG_SIZE; i++) begin
      ll_write_strobe = 1'b0;
      repeat ($urandom_range(0, 2)) @(negedge clk);
      ll_write_strobe = 1'b1;
      @(negedge clk);
    end
    ll_write_strobe   = 1'b0;
    ll_write_finished = 1'b1;
    ll_xmit_error     = err;
    // Link busy after an error so the retry waits
    if (err) link_layer_ready = 1'b0;
    @(negedge clk);
    ll_write_finished = 1'b0;
    ll_xmit_error     = 1'b0;
  endtask

  task automatic recv_frame(input logic [4:0][31:0] dw, input int n);
    logic [2:0] exp_stb;
    int i;
    case (dw[0][7:0])
      `FIS_D2H_REG:      exp_stb = 3'b100;
      `FIS_SET_DEV_BITS: exp_stb = 3'b010;
      `FIS_DMA_ACT:      exp_stb = 3'b001;
      default:           exp_stb = 3'b000;
    endcase
    exp_d2h = d2h_ref(exp_d2h, dw);
    ll_rx.start = 1'b1;
    @(negedge clk);
    ll_rx.start = 1'b0;
    for (i = 0; i < n; i++) begin
      repeat ($urandom_range(0, 1)) @(negedge clk);
      ll_rx.strobe = 1'b1;
      ll_rx.data   = dw[i];
      @(negedge clk);
      ll_rx.strobe = 1'b0;
    end
    ll_rx.finished = 1'b1;
    expect_eq("strobes before finish", {d2h_reg_stb, set_device_bits_stb, dma_activate_stb}, 0);
    @(negedge clk);
    ll_rx.finished = 1'b0;
    expect_eq("completion strobes", {d2h_reg_stb, set_device_bits_stb, dma_activate_stb},
              exp_stb);
    expect_eq("d2h registers", d2h, exp_d2h);
    @(negedge clk);
    expect_eq("strobes one cycle later", {d2h_reg_stb, set_device_bits_stb, dma_activate_stb}, 0);
    expect_eq("ready after frame", transport_layer_ready, 1'b1);
  endtask

  // Collects sent dwords and compares each finished frame with the reference
  always @(posedge clk) begin
    if (rst || sync_escape) begin
      sent_q.delete();
    end else begin
      if (ll_write_strobe) sent_q.push_back(ll_tx.data);
      if (ll_write_finished) begin
        expect_eq("sent dword count", sent_q.size(), `FIS_H2D_REG_SIZE);
        for (k = 0; k < `FIS_H2D_REG_SIZE && k < sent_q.size(); k++) begin
          expect_eq($sformatf("sent dword %0d", k), sent_q[k], exp_dw[k]);
        end
        frames_checked++;
        sent_q.delete();
      end
    end
  end

  initial begin
    seed = 61479;
    void'($urandom(seed));
    rst = 1'b1;
    send_command_stb  = 1'b0;
    send_control_stb  = 1'b0;
    sync_escape       = 1'b0;
    h2d               = '0;
    link_layer_ready  = 1'b0;
    phy_ready         = 1'b1;
    ll_rx             = '0;
    ll_write_strobe   = 1'b0;
    ll_write_finished = 1'b0;
    ll_xmit_error     = 1'b0;
    exp_d2h           = '0;
    exp_dw            = '0;
    errors = 0;
    tests = 0;
    failed_tests = 0;
    frames_checked = 0;
    timed_out = 1'b0;

    begin : run_tests
      repeat (8) @(negedge clk);
      rst = 1'b0;

      start_test("reset state");
      @(negedge clk);
      expect_eq("ready without link", transport_layer_ready, 1'b0);
      link_layer_ready = 1'b1;
      wait_ready();
      expect_eq("start after reset", ll_tx.start, 1'b0);
      expect_eq("strobes after reset", {d2h_reg_stb, set_device_bits_stb, dma_activate_stb}, 0);
      expect_eq("d2h after reset", d2h, '0);
      expect_eq("read ready", ll_read_ready, 1'b1);
      finish_test();

      start_test("command and control send");
      h2d = rand_h2d();
      exp_dw = h2d_ref(h2d, 1'b1);
      base = frames_checked;
      launch_send(1'b1);
      expect_eq("frame size", ll_tx.size, `FIS_H2D_REG_SIZE);
      link_phase(1'b0);
      h2d = rand_h2d();
      exp_dw = h2d_ref(h2d, 1'b0);
      launch_send(1'b0);
      link_phase(1'b0);
      expect_eq("frames sent", frames_checked, base + 2);
      finish_test();

      start_test("retry after transmit error");
      h2d = rand_h2d();
      exp_dw = h2d_ref(h2d, 1'b1);
      base = frames_checked;
      launch_send(1'b1);
      link_phase(1'b1);
      repeat (3) begin
        expect_eq("start while link busy", ll_tx.start, 1'b0);
        expect_eq("ready during retry", transport_layer_ready, 1'b0);
        @(negedge clk);
      end
      link_layer_ready = 1'b1;
      wait_start();
      link_phase(1'b0);
      expect_eq("frames incl. retry", frames_checked, base + 2);
      finish_test();

      start_test("d2h register frame");
      wait_ready();
      for (k = 0; k < 4; k++) rx_dw[k] = $urandom;
      rx_dw[0][7:0] = `FIS_D2H_REG;
      rx_dw[4] = $urandom;
      recv_frame(rx_dw, 5);
      finish_test();

      start_test("set device bits and dma activate");
      rx_dw = '0;
      rx_dw[0] = {$urandom_range(0, 32'hffffff), `FIS_SET_DEV_BITS};
      rx_dw[1] = $urandom;
      base = exp_d2h.status;
      recv_frame(rx_dw, 2);
      expect_eq("status bit 7 kept", d2h.status[7], base[7]);
      expect_eq("status bit 3 kept", d2h.status[3], base[3]);
      rx_dw = '0;
      rx_dw[0] = {$urandom_range(0, 32'hffffff), `FIS_DMA_ACT};
      recv_frame(rx_dw, 1);
      finish_test();

      start_test("unknown type and sync escape");
      rx_dw = '0;
      rx_dw[0] = {$urandom_range(0, 32'hffffff), 8'h5A};
      rx_dw[1] = $urandom;
      recv_frame(rx_dw, 2);
      h2d = rand_h2d();
      launch_send(1'b1);
      ll_write_strobe = 1'b1;
      repeat (2) @(negedge clk);
      ll_write_strobe = 1'b0;
      sync_escape = 1'b1;
      @(negedge clk);
      expect_eq("sync escape to link", ll_sync_escape, 1'b1);
      sync_escape = 1'b0;
      wait_ready();
      // A clean send must start again from dword 0
      exp_dw = h2d_ref(h2d, 1'b0);
      base = frames_checked;
      launch_send(1'b0);
      link_phase(1'b0);
      expect_eq("send after escape", frames_checked, base + 1);
      finish_test();
    end

    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0 && !timed_out) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- logic/sata_transport.sv
// Transport layer top with type decode, control FSM, register framer and capture
`timescale 1ns/10ps

module sata_transport import sata_fis_pkg::*, sata_link_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  // Command layer
  input  logic      send_command_stb,
  input  logic      send_control_stb,
  input  logic      sync_escape,
  input  h2d_regs_t h2d,
  output logic      transport_layer_ready,
  output d2h_regs_t d2h,
  output logic      d2h_reg_stb,
  output logic      set_device_bits_stb,
  output logic      dma_activate_stb,
  // Link layer
  input  logic      link_layer_ready,
  input  logic      phy_ready,
  input  ll_rx_t    ll_rx,
  input  logic      ll_write_strobe,
  input  logic      ll_write_finished,
  input  logic      ll_xmit_error,
  output ll_tx_t    ll_tx,
  output logic      ll_read_ready,
  output logic      ll_sync_escape
);

  fis_type_e fis_type;
  fis_type_e rx_kind;
  logic      type_valid;
  logic      rx_done;
  logic      send_go;
  logic      c_bit;

  // No read back-pressure in this design
  assign ll_read_ready  = 1'b1;
  assign ll_sync_escape = sync_escape;

  fis_type_decode i_decode (
    .clk         (clk),
    .rst         (rst),
    .sync_escape (sync_escape),
    .ll_rx       (ll_rx),
    .fis_type    (fis_type),
    .type_valid  (type_valid)
  );

  transport_ctrl i_ctrl (
    .clk                   (clk),
    .rst                   (rst),
    .sync_escape           (sync_escape),
    .send_command_stb      (send_command_stb),
    .send_control_stb      (send_control_stb),
    .link_layer_ready      (link_layer_ready),
    .ll_write_finished     (ll_write_finished),
    .ll_xmit_error         (ll_xmit_error),
    .fis_type              (fis_type),
    .type_valid            (type_valid),
    .rx_done               (rx_done),
    .send_go               (send_go),
    .c_bit                 (c_bit),
    .transport_layer_ready (transport_layer_ready),
    .rx_kind               (rx_kind)
  );

  h2d_reg_framer i_framer (
    .clk             (clk),
    .rst             (rst),
    .phy_ready       (phy_ready),
    .send_go         (send_go),
    .c_bit           (c_bit),
    .h2d             (h2d),
    .ll_write_strobe (ll_write_strobe),
    .ll_tx           (ll_tx)
  );

  d2h_reg_capture i_capture (
    .clk                 (clk),
    .rst                 (rst),
    .ll_rx               (ll_rx),
    .rx_kind             (rx_kind),
    .d2h                 (d2h),
    .d2h_reg_stb         (d2h_reg_stb),
    .set_device_bits_stb (set_device_bits_stb),
    .dma_activate_stb    (dma_activate_stb),
    .rx_done             (rx_done)
  );

endmodule

//--- logic/d2h_reg_capture.sv
// Device register capture from received frames with per-type completion strobes
`timescale 1ns/10ps
`include "sata_transport_defines.svh"

module d2h_reg_capture import sata_fis_pkg::*, sata_link_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  ll_rx_t    ll_rx,
  input  fis_type_e rx_kind,
  output d2h_regs_t d2h,
  output logic      d2h_reg_stb,
  output logic      set_device_bits_stb,
  output logic      dma_activate_stb,
  output logic      rx_done
);

  logic [2:0]          dw_cnt;
  logic [`DWORD_W-1:0] dw0;
  logic                known;

  assign known = (rx_kind == fis_d2h_reg) || (rx_kind == fis_set_dev_bits) ||
                 (rx_kind == fis_dma_act);

  // Dword position within the current frame, saturates
  always_ff @(posedge clk) begin
    if (rst) begin
      dw_cnt <= '0;
    end else if (ll_rx.start) begin
      dw_cnt <= '0;
    end else if (ll_rx.strobe && dw_cnt != 3'd7) begin
      dw_cnt <= dw_cnt + 3'd1;
    end
  end

  // The type is not known yet when dword 0 arrives
  always_ff @(posedge clk) begin
    if (ll_rx.strobe && dw_cnt == 3'd0) begin
      dw0 <= ll_rx.data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      d2h                 <= '0;
      d2h_reg_stb         <= 1'b0;
      set_device_bits_stb <= 1'b0;
      dma_activate_stb    <= 1'b0;
      rx_done             <= 1'b0;
    end else begin
      d2h_reg_stb         <= ll_rx.finished && (rx_kind == fis_d2h_reg);
      set_device_bits_stb <= ll_rx.finished && (rx_kind == fis_set_dev_bits);
      dma_activate_stb    <= ll_rx.finished && (rx_kind == fis_dma_act);
      rx_done             <= ll_rx.finished;

      // Register FIS body dwords
      if (ll_rx.strobe && rx_kind == fis_d2h_reg) begin
        case (dw_cnt)
          3'd1: begin
            d2h.device    <= ll_rx.data[31:24];
            d2h.lba[23:0] <= ll_rx.data[23:0];
          end
          3'd2: d2h.lba[47:24]    <= ll_rx.data[23:0];
          3'd3: d2h.sector_count  <= ll_rx.data[15:0];
          default: ;
        endcase
      end

      // Dword 0 fields land together with the completion strobe
      if (ll_rx.finished && known) begin
        d2h.interrupt <= dw0[14];
        d2h.port_mult <= dw0[11:8];
        if (rx_kind == fis_d2h_reg) begin
          d2h.status <= dw0[23:16];
          d2h.error  <= dw0[31:24];
        end
        if (rx_kind == fis_set_dev_bits) begin
          // Status bits 7 and 3 keep their last value
          d2h.status[6:4]  <= dw0[22:20];
          d2h.status[2:0]  <= dw0[18:16];
          d2h.error        <= dw0[31:24];
          d2h.notification <= dw0[15];
        end
      end
    end
  end

endmodule

//--- logic/h2d_reg_framer.sv
// Host-to-device register FIS framing and the phy-gated start toward the link layer
`timescale 1ns/10ps
`include "sata_transport_defines.svh"

module h2d_reg_framer import sata_fis_pkg::*, sata_link_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      phy_ready,
  input  logic      send_go,
  input  logic      c_bit,
  input  h2d_regs_t h2d,
  input  logic      ll_write_strobe,
  output ll_tx_t    ll_tx
);

  logic [2:0]          ptr;
  logic                start_q;
  logic                cmd_bit;
  logic [`DWORD_W-1:0] dword;

  // Start stays up until the phy has seen it
  always_ff @(posedge clk) begin
    if (rst) begin
      start_q <= 1'b0;
    end else if (send_go) begin
      start_q <= 1'b1;
    end else if (phy_ready) begin
      start_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (send_go) begin
      ptr <= '0;
    end else if (ll_write_strobe && ptr != 3'(`FIS_H2D_REG_SIZE)) begin
      ptr <= ptr + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (send_go) begin
      cmd_bit <= c_bit;
    end
  end

  always_comb begin
    case (ptr)
      3'd0:    dword = {h2d.features[7:0], h2d.command, cmd_bit, 3'b000, h2d.port_mult,
                        `FIS_H2D_REG};
      3'd1:    dword = {h2d.device, h2d.lba[23:0]};
      3'd2:    dword = {h2d.features[15:8], h2d.lba[47:24]};
      3'd3:    dword = {h2d.control, 8'h00, h2d.sector_count};
      // Dword 4 and past the end
      default: dword = '0;
    endcase
  end

  always_comb begin
    ll_tx.start = start_q;
    ll_tx.data  = dword;
    ll_tx.size  = `DWORD_W'(`FIS_H2D_REG_SIZE);
  end

endmodule

//--- logic/transport_ctrl.sv
// Transport control FSM for register sends, retries and received frames
`timescale 1ns/10ps

module transport_ctrl import sata_fis_pkg::*, sata_link_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      sync_escape,
  input  logic      send_command_stb,
  input  logic      send_control_stb,
  input  logic      link_layer_ready,
  input  logic      ll_write_finished,
  input  logic      ll_xmit_error,
  input  fis_type_e fis_type,
  input  logic      type_valid,
  input  logic      rx_done,
  output logic      send_go,
  output logic      c_bit,
  output logic      transport_layer_ready,
  output fis_type_e rx_kind
);

  ctrl_state_e state;
  // C bit of the FIS in flight, reused on retry
  logic        c_bit_q;

  // A type report in the same cycle takes precedence over a new send
  assign transport_layer_ready = (state == st_idle) && link_layer_ready && !type_valid;

  always_comb begin
    send_go = 1'b0;
    if (!sync_escape) begin
      if (transport_layer_ready && (send_command_stb || send_control_stb)) begin
        send_go = 1'b1;
      end else if (state == st_retry && link_layer_ready) begin
        send_go = 1'b1;
      end
    end
  end

  assign c_bit = (state == st_idle) ? send_command_stb : c_bit_q;

  // Idle passes the fresh type through so the capture sees dword 1 in time
  always_comb begin
    case (state)
      st_idle:     rx_kind = type_valid ? fis_type : fis_none;
      st_read_reg: rx_kind = fis_d2h_reg;
      st_read_sdb: rx_kind = fis_set_dev_bits;
      st_dma_act:  rx_kind = fis_dma_act;
      st_skip:     rx_kind = fis_unknown;
      default:     rx_kind = fis_none;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_idle;
      c_bit_q <= 1'b0;
    end else if (sync_escape) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (send_go) begin
            c_bit_q <= send_command_stb;
            state   <= st_write_reg;
          end else if (type_valid) begin
            case (fis_type)
              fis_d2h_reg:      state <= st_read_reg;
              fis_set_dev_bits: state <= st_read_sdb;
              fis_dma_act:      state <= st_dma_act;
              default:          state <= st_skip;
            endcase
          end
        end
        st_write_reg: begin
          if (ll_write_finished) begin
            state <= ll_xmit_error ? st_retry : st_idle;
          end
        end
        st_retry: begin
          if (send_go) begin
            state <= st_write_reg;
          end
        end
        default: begin
          if (rx_done) begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

  // A transmit finish only ends a send that is underway
  a_finish_in_send: assert property (@(posedge clk) disable iff (rst)
    ll_write_finished |-> state == st_write_reg);

endmodule

//--- logic/fis_type_decode.sv
// Type detection of received frames from the low byte of their first dword
`timescale 1ns/10ps
`include "sata_transport_defines.svh"

module fis_type_decode import sata_fis_pkg::*, sata_link_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      sync_escape,
  input  ll_rx_t    ll_rx,
  output fis_type_e fis_type,
  output logic      type_valid
);

  // Set between frame start and the first dword
  logic armed;

  function automatic fis_type_e map_type(input logic [7:0] code);
    case (code)
      `FIS_D2H_REG:      return fis_d2h_reg;
      `FIS_SET_DEV_BITS: return fis_set_dev_bits;
      `FIS_DMA_ACT:      return fis_dma_act;
      default:           return fis_unknown;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (rst || sync_escape) begin
      armed      <= 1'b0;
      fis_type   <= fis_none;
      type_valid <= 1'b0;
    end else begin
      type_valid <= 1'b0;
      if (ll_rx.finished) begin
        armed    <= 1'b0;
        fis_type <= fis_none;
      end else if (ll_rx.start) begin
        armed <= 1'b1;
      end else if (armed && ll_rx.strobe) begin
        // Type is held for the rest of the frame
        armed      <= 1'b0;
        fis_type   <= map_type(ll_rx.data[7:0]);
        type_valid <= 1'b1;
      end
    end
  end

  // One type report per frame
  a_single_type: assert property (@(posedge clk) disable iff (rst)
    type_valid && !ll_rx.finished && !sync_escape |=>
      !type_valid until (ll_rx.finished || sync_escape));

endmodule

//--- logic/sata_link_pkg.sv
// Link layer receive and transmit structs and the transport control state enum
`include "sata_transport_defines.svh"

package sata_link_pkg;

  // Receive side, driven by the link layer
  typedef struct packed {
    logic                start;
    logic                strobe;
    logic                finished;
    logic [`DWORD_W-1:0] data;
  } ll_rx_t;

  // Transmit side, driven toward the link layer
  typedef struct packed {
    logic                start;
    logic [`DWORD_W-1:0] data;
    logic [`DWORD_W-1:0] size;
  } ll_tx_t;

  // Transport control FSM states
  typedef enum logic [2:0] {
    st_idle,
    st_write_reg,
    st_retry,
    st_read_reg,
    st_read_sdb,
    st_dma_act,
    st_skip
  } ctrl_state_e;

endpackage

//--- logic/sata_fis_pkg.sv
// Received FIS type enum and the host and device shadow register structs
package sata_fis_pkg;

  // Received frame kinds as seen by the transport control
  typedef enum logic [2:0] {
    fis_none,
    fis_d2h_reg,
    fis_set_dev_bits,
    fis_dma_act,
    fis_unknown
  } fis_type_e;

  // Host shadow registers, sent as a register FIS
  typedef struct packed {
    logic [7:0]  command;
    logic [15:0] features;
    logic [7:0]  control;
    logic [3:0]  port_mult;
    logic [7:0]  device;
    logic [47:0] lba;
    logic [15:0] sector_count;
  } h2d_regs_t;

  // Device shadow registers, filled from received FIS
  typedef struct packed {
    logic        interrupt;
    logic        notification;
    logic [3:0]  port_mult;
    logic [7:0]  device;
    logic [47:0] lba;
    logic [15:0] sector_count;
    logic [7:0]  status;
    logic [7:0]  error;
  } d2h_regs_t;

endpackage

//--- logic/sata_transport_defines.svh
// FIS type codes, register FIS length and link dword width
`ifndef SATA_TRANSPORT_DEFINES_SVH
`define SATA_TRANSPORT_DEFINES_SVH

// FIS type codes as found in bits 7:0 of dword 0
`define FIS_H2D_REG       8'h27
`define FIS_D2H_REG       8'h34
`define FIS_SET_DEV_BITS  8'hA1
`define FIS_DMA_ACT       8'h39

// Register FIS length in dwords
`define FIS_H2D_REG_SIZE  5

// Width of one link layer dword
`define DWORD_W           32

`endif
